// ==== Bender.yml ====
package:
  name: buffer_gearbox

sources:
  - design/gearbox_pkg.sv
  - design/clink_pixel_packer.sv
  - design/beat_splitter.sv
  - design/cdc_async_fifo.sv
  - design/dram_write_scheduler.sv
  - design/buffer_gearbox.sv
  - target: test
    files:
      - tests/buffer_gearbox_checker.sv
      - tests/buffer_gearbox_monitor.sv
      - tests/buffer_gearbox_tb.sv

// ==== design/beat_splitter.sv ====
`timescale 1ns/1ps

module beat_splitter
    import gearbox_pkg::*;
#(
    parameter int data_width = 512
)
(
    input  logic                      clink_X_clk,
    input  logic                      clk_pixel_resetn_buffer2,
    input  logic [3*data_width-1:0]   pack_buf,
    input  logic                      pack_valid,
    output logic [data_width-1:0]     fifo_wdata,
    output logic                      fifo_wr
);

    beat_state_t             state;
    logic [2*data_width-1:0] rest;     // words 1 and 2, word 1 at the bottom
    logic                    accept;

    // a new buffer can follow straight after the last beat
    assign accept = pack_valid & ((state == IDLE) | (state == BEAT2));

    always_ff @(posedge clink_X_clk) begin
        if (!clk_pixel_resetn_buffer2) begin
            state   <= IDLE;
            fifo_wr <= 1'b0;
        end else begin
            fifo_wr <= 1'b0;
            case (state)
                IDLE, BEAT2: begin
                    if (accept) begin
                        state   <= BEAT0;
                        fifo_wr <= 1'b1;
                    end else begin
                        state <= IDLE;
                    end
                end
                BEAT0: begin
                    state   <= BEAT1;
                    fifo_wr <= 1'b1;
                end
                BEAT1: begin
                    state   <= BEAT2;
                    fifo_wr <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // word 0 goes out at once, the other two are held and shifted down
    always_ff @(posedge clink_X_clk) begin
        if (accept) begin
            fifo_wdata <= pack_buf[0 +: data_width];
            rest       <= pack_buf[3*data_width-1:data_width];
        end else if (state == BEAT0 || state == BEAT1) begin
            fifo_wdata <= rest[0 +: data_width];
            rest       <= {{data_width{1'b0}}, rest[2*data_width-1:data_width]};
        end
    end

endmodule

// ==== design/buffer_gearbox.sv ====
`timescale 1ns/1ps

module buffer_gearbox #(
    parameter int                    data_width = 512,
    parameter int                    addr_width = 32,
    parameter logic [addr_width-1:0] addr_base  = 32'h8000_0000,
    parameter int                    fifo_depth = 32
)
(
    input  logic                  clink_X_clk,
    input  logic                  m_axi_aclk,
    input  logic                  clk_pixel_resetn,
    input  logic                  axi_reset,
    input  logic [7:0]            d0,
    input  logic [7:0]            d1,
    input  logic [7:0]            d2,
    input  logic                  fval,
    input  logic                  dval,
    input  logic                  lval,
    input  logic                  dram_write_busy,
    output logic                  dram_write_en,
    output logic [addr_width-1:0] dram_write_addr,
    output logic [data_width-1:0] dram_write_data,
    output logic                  fifo_full
);

    // pixel domain
    logic                    clk_pixel_resetn_buffer2;
    logic [3*data_width-1:0] pack_buf;
    logic                    pack_valid;
    logic [data_width-1:0]   fifo_wdata;
    logic                    fifo_wr;

    // dram domain
    logic                    fifo_empty;

    clink_pixel_packer #(
        .data_width (data_width)
    ) clink_pixel_packer_i (
        .clink_X_clk              (clink_X_clk),
        .clk_pixel_resetn         (clk_pixel_resetn),
        .d0                       (d0),
        .d1                       (d1),
        .d2                       (d2),
        .fval                     (fval),
        .dval                     (dval),
        .lval                     (lval),
        .clk_pixel_resetn_buffer2 (clk_pixel_resetn_buffer2),
        .pack_buf                 (pack_buf),
        .pack_valid               (pack_valid)
    );

    beat_splitter #(
        .data_width (data_width)
    ) beat_splitter_i (
        .clink_X_clk              (clink_X_clk),
        .clk_pixel_resetn_buffer2 (clk_pixel_resetn_buffer2),
        .pack_buf                 (pack_buf),
        .pack_valid               (pack_valid),
        .fifo_wdata               (fifo_wdata),
        .fifo_wr                  (fifo_wr)
    );

    // fifo head drives the dram write data directly
    cdc_async_fifo #(
        .data_width (data_width),
        .fifo_depth (fifo_depth)
    ) cdc_async_fifo_i (
        .clink_X_clk              (clink_X_clk),
        .clk_pixel_resetn_buffer2 (clk_pixel_resetn_buffer2),
        .m_axi_aclk               (m_axi_aclk),
        .axi_reset                (axi_reset),
        .fifo_wdata               (fifo_wdata),
        .fifo_wr                  (fifo_wr),
        .fifo_full                (fifo_full),
        .fifo_rdata               (dram_write_data),
        .fifo_empty               (fifo_empty),
        .dram_write_en            (dram_write_en)
    );

    dram_write_scheduler #(
        .data_width (data_width),
        .addr_width (addr_width),
        .addr_base  (addr_base)
    ) dram_write_scheduler_i (
        .m_axi_aclk      (m_axi_aclk),
        .axi_reset       (axi_reset),
        .fifo_empty      (fifo_empty),
        .dram_write_busy (dram_write_busy),
        .dram_write_en   (dram_write_en),
        .dram_write_addr (dram_write_addr)
    );

endmodule

// ==== design/cdc_async_fifo.sv ====
`timescale 1ns/1ps

module cdc_async_fifo #(
    parameter int data_width = 512,
    parameter int fifo_depth = 32
)
(
    input  logic                  clink_X_clk,
    input  logic                  clk_pixel_resetn_buffer2,
    input  logic                  m_axi_aclk,
    input  logic                  axi_reset,
    input  logic [data_width-1:0] fifo_wdata,
    input  logic                  fifo_wr,
    output logic                  fifo_full,
    output logic [data_width-1:0] fifo_rdata,
    output logic                  fifo_empty,
    input  logic                  dram_write_en
);

    localparam int aw = $clog2(fifo_depth);

    // full when the two top gray bits differ and the rest match
    localparam logic [aw:0] full_mask = {2'b11, {(aw-1){1'b0}}};

    logic [data_width-1:0] mem [fifo_depth];

    logic [aw:0] wbin;
    logic [aw:0] wgray;
    logic [aw:0] wbin_next;
    logic [aw:0] rgray_q1;
    logic [aw:0] rgray_q2;     // read pointer in write domain

    logic [aw:0] rbin;
    logic [aw:0] rgray;
    logic [aw:0] rbin_next;
    logic [aw:0] wgray_q1;
    logic [aw:0] wgray_q2;     // write pointer in read domain

    logic push;
    logic pop;

    assign wbin_next = wbin + 1'b1;
    assign rbin_next = rbin + 1'b1;

    assign fifo_full  = (wgray == (rgray_q2 ^ full_mask));
    assign fifo_empty = (rgray == wgray_q2);

    assign push = fifo_wr & ~fifo_full;            // writes while full are dropped
    assign pop  = dram_write_en & ~fifo_empty;

    // show-ahead, head word sits on the output before the pop
    assign fifo_rdata = mem[rbin[aw-1:0]];

    always_ff @(posedge clink_X_clk) begin
        if (push) begin
            mem[wbin[aw-1:0]] <= fifo_wdata;
        end
    end

    always_ff @(posedge clink_X_clk) begin
        if (!clk_pixel_resetn_buffer2) begin
            wbin     <= '0;
            wgray    <= '0;
            rgray_q1 <= '0;
            rgray_q2 <= '0;
        end else begin
            rgray_q1 <= rgray;
            rgray_q2 <= rgray_q1;
            if (push) begin
                wbin  <= wbin_next;
                wgray <= (wbin_next >> 1) ^ wbin_next;
            end
        end
    end

    always_ff @(posedge m_axi_aclk) begin
        if (axi_reset) begin
            rbin     <= '0;
            rgray    <= '0;
            wgray_q1 <= '0;
            wgray_q2 <= '0;
        end else begin
            wgray_q1 <= wgray;
            wgray_q2 <= wgray_q1;
            if (pop) begin
                rbin  <= rbin_next;
                rgray <= (rbin_next >> 1) ^ rbin_next;
            end
        end
    end

endmodule

// ==== design/clink_pixel_packer.sv ====
`timescale 1ns/1ps

module clink_pixel_packer
    import gearbox_pkg::*;
#(
    parameter int data_width = 512
)
(
    input  logic                      clink_X_clk,
    input  logic                      clk_pixel_resetn,
    input  logic [7:0]                d0,
    input  logic [7:0]                d1,
    input  logic [7:0]                d2,
    input  logic                      fval,
    input  logic                      dval,
    input  logic                      lval,
    output logic                      clk_pixel_resetn_buffer2,
    output logic [3*data_width-1:0]   pack_buf,
    output logic                      pack_valid
);

    localparam int buf_bits = 3 * data_width;
    localparam int slots    = buf_bits / pixel_bits;
    localparam int idx_w    = (slots > 1) ? $clog2(slots) : 1;

    logic             resetn_buffer1;
    logic [idx_w-1:0] slot_idx;
    logic             line_q;      // fval & lval seen last cycle
    logic             pix_valid;
    logic             line_valid;
    logic             line_end;
    logic             buf_last;

    assign pix_valid  = fval & dval & lval;
    assign line_valid = fval & lval;
    assign buf_last   = (slot_idx == idx_w'(slots - 1));

    // end of line follows lval, so dval gaps inside a line do not flush
    assign line_end = line_q & ~line_valid & (slot_idx != '0);

    // two-stage synchronizer for the pixel reset
    always_ff @(posedge clink_X_clk) begin
        resetn_buffer1           <= clk_pixel_resetn;
        clk_pixel_resetn_buffer2 <= resetn_buffer1;
    end

    always_ff @(posedge clink_X_clk) begin
        if (!clk_pixel_resetn_buffer2) begin
            slot_idx   <= '0;
            line_q     <= 1'b0;
            pack_valid <= 1'b0;
        end else begin
            line_q     <= line_valid;
            pack_valid <= 1'b0;
            if (pix_valid) begin
                if (buf_last) begin
                    pack_valid <= 1'b1;     // buffer full
                    slot_idx   <= '0;
                end else begin
                    slot_idx <= slot_idx + 1'b1;
                end
            end else if (line_end) begin
                pack_valid <= 1'b1;         // partial buffer, rest stays zero
                slot_idx   <= '0;
            end
        end
    end

    // slot 0 wipes the old contents so a flushed buffer is zero padded
    always_ff @(posedge clink_X_clk) begin
        if (pix_valid) begin
            if (slot_idx == '0) begin
                pack_buf <= {{(buf_bits - pixel_bits){1'b0}}, d2, d1, d0};
            end else begin
                pack_buf[slot_idx*pixel_bits +: pixel_bits] <= {d2, d1, d0};
            end
        end
    end

endmodule

// ==== design/dram_write_scheduler.sv ====
`timescale 1ns/1ps

module dram_write_scheduler
    import gearbox_pkg::*;
#(
    parameter int                    data_width = 512,
    parameter int                    addr_width = 32,
    parameter logic [addr_width-1:0] addr_base  = 32'h8000_0000
)
(
    input  logic                  m_axi_aclk,
    input  logic                  axi_reset,
    input  logic                  fifo_empty,
    input  logic                  dram_write_busy,
    output logic                  dram_write_en,
    output logic [addr_width-1:0] dram_write_addr
);

    localparam int cnt_w = $clog2(wait_cycles);

    // one dram word in bytes
    localparam logic [addr_width-1:0] addr_step = addr_width'(data_width / 8);

    sched_state_t     state;
    logic [cnt_w-1:0] hold_cnt;

    always_ff @(posedge m_axi_aclk) begin
        if (axi_reset) begin
            state           <= READY;
            hold_cnt        <= '0;
            dram_write_en   <= 1'b0;
            dram_write_addr <= addr_base;
        end else begin
            dram_write_en <= 1'b0;

            // address moves on once the write has been presented
            if (dram_write_en) begin
                dram_write_addr <= dram_write_addr + addr_step;
            end

            case (state)
                READY: begin
                    if (!fifo_empty && !dram_write_busy) begin
                        dram_write_en <= 1'b1;   // also pops the fifo head
                        state         <= HOLDOFF;
                        hold_cnt      <= '0;
                    end
                end
                HOLDOFF: begin
                    // wait_cycles - 1 cycles here, issue cycle included
                    hold_cnt <= hold_cnt + 1'b1;
                    if (hold_cnt == cnt_w'(wait_cycles - 2)) begin
                        state <= READY;
                    end
                end
                default: state <= READY;
            endcase
        end
    end

endmodule

// ==== design/gearbox_pkg.sv ====
package gearbox_pkg;

    // one camera link pixel group, three bytes per clock
    localparam int pixel_bits = 24;

    // dram-side spacing between writes, the issue cycle counts
    localparam int wait_cycles = 16;

    // splitter state names the word on fifo_wdata
    typedef enum logic [1:0] {
        IDLE,
        BEAT0,
        BEAT1,
        BEAT2
    } beat_state_t;

    typedef enum logic {
        READY,
        HOLDOFF
    } sched_state_t;

endpackage

// ==== src.f ====
design/gearbox_pkg.sv
design/clink_pixel_packer.sv
design/beat_splitter.sv
design/cdc_async_fifo.sv
design/dram_write_scheduler.sv
design/buffer_gearbox.sv
tests/buffer_gearbox_checker.sv
tests/buffer_gearbox_monitor.sv
tests/buffer_gearbox_tb.sv

// ==== tests/buffer_gearbox_checker.sv ====
`timescale 1ns/1ps

module buffer_gearbox_checker
    import gearbox_pkg::*;
(
    input logic clink_X_clk,
    input logic clk_pixel_resetn_buffer2,
    input logic pack_valid,
    input logic fifo_wr,
    input logic fifo_full,
    input logic m_axi_aclk,
    input logic axi_reset,
    input logic dram_write_en
);

    int failures = 0;   // read by the testbench at the end

    // splitter only takes a buffer in IDLE or BEAT2
    pack_spacing: assert property (@(posedge clink_X_clk) disable iff (!clk_pixel_resetn_buffer2)
        pack_valid |-> !$past(pack_valid) && !$past(pack_valid, 2))
        else begin
            $error("pack_valid arrived while the splitter was in BEAT0 or BEAT1");
            failures++;
        end

    beat_triple: assert property (@(posedge clink_X_clk) disable iff (!clk_pixel_resetn_buffer2)
        pack_valid |=> fifo_wr [*3])
        else begin
            $error("buffer did not produce three fifo writes");
            failures++;
        end

    beat_source: assert property (@(posedge clink_X_clk) disable iff (!clk_pixel_resetn_buffer2)
        fifo_wr |-> $past(pack_valid) || $past(pack_valid, 2) || $past(pack_valid, 3))
        else begin
            $error("fifo write without a buffer behind it");
            failures++;
        end

    write_not_full: assert property (@(posedge clink_X_clk) disable iff (!clk_pixel_resetn_buffer2)
        fifo_wr |-> !fifo_full)
        else begin
            $error("fifo write while fifo_full was high");
            failures++;
        end

    // issue cycle plus wait_cycles - 1 quiet cycles
    write_holdoff: assert property (@(posedge m_axi_aclk) disable iff (axi_reset)
        dram_write_en |=> !dram_write_en [*(wait_cycles - 1)])
        else begin
            $error("dram write issued inside the holdoff window");
            failures++;
        end

endmodule

bind buffer_gearbox buffer_gearbox_checker buffer_gearbox_checker_i (
    .clink_X_clk              (clink_X_clk),
    .clk_pixel_resetn_buffer2 (clk_pixel_resetn_buffer2),
    .pack_valid               (pack_valid),
    .fifo_wr                  (fifo_wr),
    .fifo_full                (fifo_full),
    .m_axi_aclk               (m_axi_aclk),
    .axi_reset                (axi_reset),
    .dram_write_en            (dram_write_en)
);

// ==== tests/buffer_gearbox_monitor.sv ====
`timescale 1ns/1ps

module buffer_gearbox_monitor
    import gearbox_pkg::*;
#(
    parameter int                    data_width = 512,
    parameter int                    addr_width = 32,
    parameter logic [addr_width-1:0] addr_base  = 32'h8000_0000
)
(
    input  logic                  clink_X_clk,
    input  logic                  m_axi_aclk,
    input  logic                  clk_pixel_resetn,
    input  logic                  axi_reset,
    input  logic [7:0]            d0,
    input  logic [7:0]            d1,
    input  logic [7:0]            d2,
    input  logic                  fval,
    input  logic                  dval,
    input  logic                  lval,
    input  logic                  dram_write_busy,
    input  logic                  dram_write_en,
    input  logic [addr_width-1:0] dram_write_addr,
    input  logic [data_width-1:0] dram_write_data,
    input  logic                  fifo_full,
    input  logic                  run_done,
    output int                    errors,
    output int                    pending
);

    localparam int slots = 3 * data_width / pixel_bits;

    logic [3*data_width-1:0] model_buf;
    logic [data_width-1:0]   exp_q[$];
    logic [data_width-1:0]   exp_word;
    int slot = 0;
    bit line_q = 0;
    int buf_count = 0;
    int wr_count = 0;
    int gap = wait_cycles;        // dram cycles since the last write
    bit busy_q = 0;
    bit final_done = 0;
    int pix_errors = 0;
    int dram_errors = 0;

    assign errors  = pix_errors + dram_errors;
    assign pending = 3 * buf_count - wr_count;

    function automatic int report_mismatch(string name, logic [data_width-1:0] exp,
                                           logic [data_width-1:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %0h actual %0h", name, exp, act);
            return 1;
        end
        return 0;
    endfunction

    // three words per buffer, earliest pixels in word 0
    task automatic push_buffer();
        for (int k = 0; k < 3; k++) begin
            exp_q.push_back(model_buf[k*data_width +: data_width]);
        end
        buf_count++;
        model_buf = '0;   // unfilled slots of the next buffer read zero
        slot = 0;
    endtask

    always @(posedge clink_X_clk) begin
        if (!clk_pixel_resetn) begin
            model_buf = '0;
            slot = 0;
            line_q = 0;
        end else begin
            if (fval && lval && dval) begin
                model_buf[slot*pixel_bits +: pixel_bits] = {d2, d1, d0};
                slot++;
                if (slot == slots) push_buffer();
            end else if (line_q && !(fval && lval) && slot != 0) begin
                push_buffer();    // line end flush
            end
            line_q = fval && lval;
        end
        // neither reset nor paced lines may fill the fifo
        if (fifo_full === 1'b1) begin
            $display("fifo_full went high during reset or although lines are paced");
            pix_errors++;
        end
        if (run_done && !final_done) begin
            final_done = 1;
            pix_errors += report_mismatch("write_count", 3 * buf_count, wr_count);
        end
    end

    always @(posedge m_axi_aclk) begin
        if (axi_reset) begin
            if (dram_write_en === 1'b1) begin
                $display("dram_write_en was high during reset");
                dram_errors++;
            end
            busy_q = 0;
            gap = wait_cycles;
        end else begin
            gap++;
            if (dram_write_en === 1'b1) begin
                if (busy_q) begin
                    $display("dram write issued while dram_write_busy was high");
                    dram_errors++;
                end
                if (gap < wait_cycles) begin
                    $display("dram write came %0d cycles after the previous one", gap);
                    dram_errors++;
                end
                gap = 0;
                if (exp_q.size() == 0) begin
                    $display("dram write with no expected word left in the model");
                    dram_errors++;
                end else begin
                    exp_word = exp_q.pop_front();
                    dram_errors += report_mismatch("write_data", exp_word, dram_write_data);
                    dram_errors += report_mismatch("write_addr",
                        addr_base + addr_width'(wr_count * (data_width / 8)), dram_write_addr);
                end
                wr_count++;
            end
            busy_q = dram_write_busy;
        end
    end

endmodule

// ==== tests/buffer_gearbox_tb.sv ====
`timescale 1ns/1ps

module buffer_gearbox_tb;

    localparam int          data_width     = 512;
    localparam int          addr_width     = 32;
    localparam logic [31:0] addr_base      = 32'h8000_0000;
    localparam int          fifo_depth     = 32;
    localparam int          num_lines      = 40;
    localparam int          timeout_cycles = num_lines * (150 + 80 + 20) + 2000;

    logic clink_X_clk;
    logic m_axi_aclk;
    logic clk_pixel_resetn;
    logic axi_reset;
    logic [7:0] d0;
    logic [7:0] d1;
    logic [7:0] d2;
    logic fval;
    logic dval;
    logic lval;
    logic dram_write_busy;
    logic dram_write_en;
    logic [addr_width-1:0] dram_write_addr;
    logic [data_width-1:0] dram_write_data;
    logic fifo_full;
    logic run_done;

    int seed = 32'hd9c969bb;
    int busy_seed = 32'hd9c969bb + 1;   // own stream for the dram side
    int cycle_count = 0;
    int line_len;
    int idle_len;
    int mon_errors;
    int pending;
    int assert_errors;

    always #4 clink_X_clk = ~clink_X_clk;
    always #2 m_axi_aclk = ~m_axi_aclk;

    buffer_gearbox #(
        .data_width (data_width),
        .addr_width (addr_width),
        .addr_base  (addr_base),
        .fifo_depth (fifo_depth)
    ) buffer_gearbox_i (.*);

    buffer_gearbox_monitor #(
        .data_width (data_width),
        .addr_width (addr_width),
        .addr_base  (addr_base)
    ) monitor_i (
        .errors  (mon_errors),
        .pending (pending),
        .*
    );

    // one pixel clock with fresh random data, dval busy 3 of 4 cycles
    task automatic step_pixel(input bit line_on, output bit took);
        d0 = $random(seed);
        d1 = $random(seed);
        d2 = $random(seed);
        lval = line_on;
        dval = ($unsigned($random(seed)) % 4) != 0;
        took = line_on && dval;
        @(posedge clink_X_clk);
        #1;
    endtask

    task automatic send_line(input int n);
        int sent;
        bit took;
        sent = 0;
        while (sent < n) begin
            step_pixel(1'b1, took);
            if (took) sent++;
        end
    endtask

    always @(posedge m_axi_aclk) begin
        #1 dram_write_busy <= ($unsigned($random(busy_seed)) % 4) == 0;
    end

    always @(posedge clink_X_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: dram writes did not drain within %0d pixel cycles",
                     timeout_cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        bit took;
        clink_X_clk = 0;
        m_axi_aclk = 0;
        clk_pixel_resetn = 0;
        axi_reset = 1;
        d0 = 0;
        d1 = 0;
        d2 = 0;
        fval = 0;
        dval = 0;
        lval = 0;
        dram_write_busy = 0;
        run_done = 0;
        repeat (8) @(posedge clink_X_clk);
        #1;
        clk_pixel_resetn = 1;
        axi_reset = 0;
        repeat (4) @(posedge clink_X_clk);
        #1;

        fval = 1;
        for (int line = 0; line < num_lines; line++) begin
            case (line)
                0: line_len = 150;   // two full buffers and a flush
                1: line_len = 2;
                2: line_len = 64;    // exactly one buffer, no flush
                default: line_len = 2 + $unsigned($random(seed)) % 149;
            endcase
            // a lone pixel after a full buffer would flush inside BEAT1
            if (line_len % 64 == 1) line_len++;
            send_line(line_len);
            idle_len = 40 + $unsigned($random(seed)) % 41;
            repeat (idle_len) step_pixel(1'b0, took);
        end
        fval = 0;

        while (pending > 0) begin
            @(posedge clink_X_clk);
            #1;
        end
        // room for a stray extra write to show up before the count compare
        repeat (100) @(posedge clink_X_clk);
        #1;
        run_done = 1;
        repeat (2) @(posedge clink_X_clk);
        #1;
        assert_errors = buffer_gearbox_i.buffer_gearbox_checker_i.failures;
        $display("errors: monitor %0d, assertions %0d", mon_errors, assert_errors);
        if (mon_errors == 0 && assert_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
